// File: src/drv_pkg.sv
// Shared constants, state and mode enums and bus structs for the DDR2 traffic driver.
// Imported by every RTL module of the driver.
`default_nettype none

package drv_pkg;

  // --------------------------------------------------
  // widths
  localparam int DATA_W     = 32;
  localparam int LANE_W     = 8;
  localparam int BYTE_LANES = 4;
  localparam int BANK_W     = 3;
  localparam int ROW_W      = 14;
  localparam int COL_W      = 10;
  localparam int STATUS_W   = 8;

  // test range, 5 cols x 4 rows x 8 banks of bursts
  localparam int BURST_LEN = 2;
  localparam int BEAT_W    = 1;
  localparam int OUTST_W   = 10;
  localparam int COL_STEP  = 4;
  localparam int MAX_COL   = 16;
  localparam int MAX_ROW   = 3;
  localparam int MAX_BANK  = 7;

  // lane 0 in the low byte
  localparam logic [BYTE_LANES-1:0][LANE_W-1:0] LANE_SEEDS = {8'd31, 8'd21, 8'd11, 8'd1};

  // --------------------------------------------------
  typedef enum logic [3:0] {
    IDLE, START, WR_BURST, WR_BEAT, WR_LAST,
    RD_START, RD_BURST, RD_DRAIN, NEXT_TEST, DONE
  } drv_state_e;

  typedef enum logic [1:0] {NONE, SEQ_ADDR, BYTE_MASK} test_mode_e;

  typedef struct packed {
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;
  } mem_addr_t;

  // sequencer commands to the address and pattern generators
  typedef struct packed {
    logic addr_clear;
    logic addr_step;
    logic wr_beat;
    logic seed_capture;
    logic pattern_reload;
    logic be_clear;
    logic zero_data;
    logic mask_mode;
  } seq_ctrl_t;

endpackage

`default_nettype wire

// File: src/test_sequencer.sv
// Test-phase FSM of the traffic driver. Runs the sequential address test and then
// the byte-mask test, raises the local-port request levels and burst_begin, and
// sends step/clear commands to the address and pattern generators.
`default_nettype none

module test_sequencer
  import drv_pkg::*;
(
  input  wire                 clk,
  input  wire                 reset_n,
  input  wire                 ready,
  input  wire                 rdata_valid,
  input  wire                 last_addr,
  output logic                write_req,
  output logic                read_req,
  output logic                burst_begin,
  output seq_ctrl_t           ctrl,
  output logic [STATUS_W-1:0] test_status,
  output logic                test_complete
);

  drv_state_e         state;
  test_mode_e         mode;
  logic [BEAT_W-1:0]  beat_cnt;
  logic [OUTST_W-1:0] outstanding;
  logic [OUTST_W-1:0] rd_add;
  logic [OUTST_W-1:0] rd_sub;
  logic               zero_pass;
  logic               first_beat;
  logic               wr_accept;
  logic               rd_accept;
  logic               burst_done;

  assign wr_accept  = write_req & ready;
  assign rd_accept  = read_req & ready;
  assign burst_done = wr_accept & (state == WR_BEAT) & (beat_cnt == BEAT_W'(BURST_LEN - 1));

  // --------------------------------------------------
  // main FSM
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= IDLE;
      mode          <= NONE;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      burst_begin   <= 1'b0;
      beat_cnt      <= '0;
      zero_pass     <= 1'b0;
      first_beat    <= 1'b0;
      test_complete <= 1'b0;
    end
    else
    begin
      test_complete <= 1'b0;
      if (wr_accept)
        first_beat <= 1'b0;
      case (state)
        IDLE:
        begin
          mode  <= SEQ_ADDR;
          state <= START;
        end
        START:
        begin
          write_req   <= 1'b1;
          burst_begin <= 1'b1;
          beat_cnt    <= '0;
          first_beat  <= 1'b1;
          state       <= WR_BURST;
        end
        WR_BURST:
          if (wr_accept)
          begin
            burst_begin <= 1'b0;
            beat_cnt    <= beat_cnt + 1'b1;
            state       <= WR_BEAT;
          end
        WR_BEAT:
          if (burst_done)
          begin
            beat_cnt <= '0;
            if (last_addr)
            begin
              write_req <= 1'b0;
              state     <= WR_LAST;
            end
            else
            begin
              burst_begin <= 1'b1;
              state       <= WR_BURST;
            end
          end
          else if (wr_accept)
            beat_cnt <= beat_cnt + 1'b1;
        // zero fill done, rewrite the range with the lane walk
        WR_LAST:
          if (zero_pass)
          begin
            zero_pass <= 1'b0;
            state     <= START;
          end
          else
            state <= RD_START;
        RD_START:
        begin
          read_req    <= 1'b1;
          burst_begin <= 1'b1;
          state       <= RD_BURST;
        end
        RD_BURST:
          if (rd_accept && last_addr)
          begin
            read_req    <= 1'b0;
            burst_begin <= 1'b0;
            state       <= RD_DRAIN;
          end
        RD_DRAIN:
          if (outstanding == '0)
            state <= NEXT_TEST;
        NEXT_TEST:
          if (mode == SEQ_ADDR)
          begin
            mode      <= BYTE_MASK;
            zero_pass <= 1'b1;
            state     <= START;
          end
          else
            state <= DONE;
        DONE:
        begin
          test_complete <= 1'b1;
          mode          <= NONE;
          state         <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // read beats still in flight
  assign rd_add = rd_accept ? OUTST_W'(BURST_LEN) : '0;
  assign rd_sub = rdata_valid ? OUTST_W'(1) : '0;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      outstanding <= '0;
    else
      outstanding <= outstanding + rd_add - rd_sub;
  end

  always_comb
  begin
    ctrl                = '0;
    ctrl.addr_clear     = (state == START) || (state == RD_START);
    ctrl.addr_step      = burst_done | rd_accept;
    ctrl.wr_beat        = wr_accept;
    ctrl.seed_capture   = first_beat;
    ctrl.pattern_reload = (state == RD_START);
    ctrl.be_clear       = (state == START) || (state == RD_START);
    ctrl.zero_data      = zero_pass;
    ctrl.mask_mode      = (mode == BYTE_MASK);
  end

  // one-hot status, bit 7 is the completion pulse
  assign test_status = {test_complete, 4'b0000, mode == BYTE_MASK, 1'b0, mode == SEQ_ADDR};

endmodule

`default_nettype wire

// File: src/addr_gen.sv
// Address generator for the local port. Walks column, then row, then bank over
// the test range on each addr_step from the sequencer; addr_clear restarts the walk.
`default_nettype none

module addr_gen
  import drv_pkg::*;
(
  input  wire       clk,
  input  wire       reset_n,
  input  seq_ctrl_t ctrl,
  output mem_addr_t addr,
  output logic      last_addr
);

  logic col_wrap;
  logic row_wrap;
  logic bank_wrap;

  assign col_wrap  = (addr.col >= COL_W'(MAX_COL));
  assign row_wrap  = (addr.row == ROW_W'(MAX_ROW));
  assign bank_wrap = (addr.bank == BANK_W'(MAX_BANK));

  // --------------------------------------------------
  // column steps by one burst, carry into row then bank
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      addr <= '0;
    else if (ctrl.addr_clear)
      addr <= '0;
    else if (ctrl.addr_step)
    begin
      if (col_wrap)
      begin
        addr.col <= '0;
        if (row_wrap)
        begin
          addr.row <= '0;
          if (bank_wrap)
            addr.bank <= '0;
          else
            addr.bank <= addr.bank + 1'b1;
        end
        else
          addr.row <= addr.row + 1'b1;
      end
      else
        addr.col <= addr.col + COL_W'(COL_STEP);
    end
  end

  // top of the range
  assign last_addr = (addr.col == COL_W'(MAX_COL)) & row_wrap & bank_wrap;

endmodule

`default_nettype wire

// File: src/pattern_gen.sv
// Write and expected-data generator. One 8-bit LFSR per byte lane, stepped per
// written beat and per returned read beat, with a seed register so the read pass
// can replay the written stream. Also drives the walking byte enable of the mask test.
`default_nettype none

module pattern_gen
  import drv_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset_n,
  input  seq_ctrl_t              ctrl,
  input  wire                    rdata_valid,
  output logic [DATA_W-1:0]      wdata,
  output logic [DATA_W-1:0]      expect_data,
  output logic [BYTE_LANES-1:0]  be
);

  logic [BYTE_LANES-1:0][LANE_W-1:0] lfsr_q;
  logic [BYTE_LANES-1:0][LANE_W-1:0] seed_q;
  logic                              step;

  // x^8+x^6+x^5+x^4+1, shift left, new bit into bit 0
  function automatic logic [LANE_W-1:0] lfsr_next(input logic [LANE_W-1:0] cur);
    logic fb;
    fb = cur[7] ^ cur[5] ^ cur[4] ^ cur[3];
    return {cur[LANE_W-2:0], fb};
  endfunction

  // zero-fill beats do not consume pattern
  assign step = (ctrl.wr_beat & ~ctrl.zero_data) | rdata_valid;

  // --------------------------------------------------
  // lane LFSRs and seed store
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      lfsr_q <= LANE_SEEDS;
      seed_q <= LANE_SEEDS;
    end
    else
    begin
      if (ctrl.seed_capture)
        seed_q <= lfsr_q;
      if (ctrl.pattern_reload)
        lfsr_q <= seed_q;
      else if (step)
      begin
        for (int i = 0; i < BYTE_LANES; i++)
          lfsr_q[i] <= lfsr_next(lfsr_q[i]);
      end
    end
  end

  assign wdata       = ctrl.zero_data ? '0 : lfsr_q;
  assign expect_data = lfsr_q;

  // --------------------------------------------------
  // byte enables, one lane per beat in the mask test
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (!ctrl.mask_mode || ctrl.zero_data)
      be <= '1;
    else if (ctrl.be_clear)
      be <= BYTE_LANES'(1);
    else if (step)
      be <= {be[BYTE_LANES-2:0], be[BYTE_LANES-1]};
  end

endmodule

`default_nettype wire

// File: src/read_checker.sv
// Read-data checker. Compares each byte lane of a valid read beat against the
// expected pattern under its byte enable and produces registered pass flags:
// pnf_per_byte three cycles after rdata_valid, the sticky pnf_persist one cycle later.
`default_nettype none

module read_checker
  import drv_pkg::*;
(
  input  wire                     clk,
  input  wire                     reset_n,
  input  wire                     rdata_valid,
  input  wire [DATA_W-1:0]        rdata,
  input  wire [DATA_W-1:0]        expect_data,
  input  wire [BYTE_LANES-1:0]    be,
  output logic [BYTE_LANES-1:0]   pnf_per_byte,
  output logic                    pnf_persist
);

  logic [BYTE_LANES-1:0] lane_match;
  logic [BYTE_LANES-1:0] match_q;
  logic [BYTE_LANES-1:0] lane_pass;
  logic                  valid_q;
  logic                  seen_data;
  logic                  seen_d1;
  logic                  seen_d2;
  logic                  persist_pre;

  for (genvar i = 0; i < BYTE_LANES; i++)
  begin : g_lane
    assign lane_match[i] = (expect_data[i*LANE_W +: LANE_W] & {LANE_W{be[i]}}) ==
                           rdata[i*LANE_W +: LANE_W];
  end

  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      match_q      <= '0;
      valid_q      <= 1'b0;
      lane_pass    <= '0;
      pnf_per_byte <= '0;
      seen_data    <= 1'b0;
      seen_d1      <= 1'b0;
      seen_d2      <= 1'b0;
      persist_pre  <= 1'b0;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      match_q <= lane_match;
      valid_q <= rdata_valid;
      // hold the last valid compare between beats
      if (valid_q)
        lane_pass <= match_q;
      pnf_per_byte <= lane_pass;
      seen_data    <= seen_data | rdata_valid;
      seen_d1      <= seen_data;
      seen_d2      <= seen_d1;
      // sticky once the first compare is in
      persist_pre  <= (&lane_pass) & seen_d1 & (seen_d2 ? persist_pre : 1'b1);
      pnf_persist  <= persist_pre;
    end
  end

endmodule

`default_nettype wire

// File: src/traffic_driver.sv
// Top of the DDR2 local-port traffic driver. Connects the test sequencer, the
// address and pattern generators and the read checker to the local port and
// brings out the pass flags, the test status and the completion pulse.
`default_nettype none

module traffic_driver
  import drv_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   ready,
  input  wire                   rdata_valid,
  input  wire [DATA_W-1:0]      rdata,
  output logic                  write_req,
  output logic                  read_req,
  output logic                  burst_begin,
  output mem_addr_t             addr,
  output logic [DATA_W-1:0]     wdata,
  output logic [BYTE_LANES-1:0] be,
  output logic [BYTE_LANES-1:0] pnf_per_byte,
  output logic                  pnf_persist,
  output logic [STATUS_W-1:0]   test_status,
  output logic                  test_complete
);

  seq_ctrl_t         ctrl;
  logic              last_addr;
  logic [DATA_W-1:0] expect_data;

  // decode
  test_sequencer u_seq (
    .clk          (clk),
    .reset_n      (reset_n),
    .ready        (ready),
    .rdata_valid  (rdata_valid),
    .last_addr    (last_addr),
    .write_req    (write_req),
    .read_req     (read_req),
    .burst_begin  (burst_begin),
    .ctrl         (ctrl),
    .test_status  (test_status),
    .test_complete(test_complete)
  );

  // execute
  addr_gen u_addr (
    .clk      (clk),
    .reset_n  (reset_n),
    .ctrl     (ctrl),
    .addr     (addr),
    .last_addr(last_addr)
  );

  pattern_gen u_pat (
    .clk        (clk),
    .reset_n    (reset_n),
    .ctrl       (ctrl),
    .rdata_valid(rdata_valid),
    .wdata      (wdata),
    .expect_data(expect_data),
    .be         (be)
  );

  // result
  read_checker u_chk (
    .clk         (clk),
    .reset_n     (reset_n),
    .rdata_valid (rdata_valid),
    .rdata       (rdata),
    .expect_data (expect_data),
    .be          (be),
    .pnf_per_byte(pnf_per_byte),
    .pnf_persist (pnf_persist)
  );

endmodule

`default_nettype wire

// File: dv/mem_model.sv
// Behavioral local-port memory for the traffic driver testbench. Stores write beats
// under their byte enables, returns read beats in order after a set latency, drops
// ready from an LFSR and can corrupt one lane of one chosen read beat.
`default_nettype none

module mem_model
  import drv_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   write_req,
  input  wire                   read_req,
  input  wire                   burst_begin,
  input  mem_addr_t             addr,
  input  wire [DATA_W-1:0]      wdata,
  input  wire [BYTE_LANES-1:0]  be,
  input  wire [2:0]             stall,
  input  wire [7:0]             latency,
  input  wire [BYTE_LANES-1:0]  fault_lanes,
  input  wire [11:0]            fault_beat,
  output logic                  ready,
  output logic                  rdata_valid,
  output logic [DATA_W-1:0]     rdata,
  output logic                  fault_hit,
  output int                    wr_beats,
  output int                    wr_bursts,
  output int                    rd_reqs,
  output int                    rd_beats
);

  typedef struct packed {
    int key;
    int due;
  } rd_entry_t;

  logic [DATA_W-1:0] mem [int];
  int                hits [int];
  rd_entry_t         rd_q [$];
  rd_entry_t         ent;
  logic [15:0]       lfsr;
  logic [2:0]        pick;
  logic [DATA_W-1:0] cur;
  int                key;
  int                cyc;
  logic              live;

  // x^16+x^14+x^13+x^11+1, one new bit per step
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  initial
  begin
    ready       = 1'b0;
    rdata_valid = 1'b0;
    rdata       = '0;
    fault_hit   = 1'b0;
    wr_beats    = 0;
    wr_bursts   = 0;
    rd_reqs     = 0;
    rd_beats    = 0;
    lfsr        = 16'd13;
    cyc         = 0;
    live        = 1'b0;
    forever
    begin
      // --------------------------------------------------
      // accepted beats, sampled mid-cycle
      @(negedge clk);
      // reset as seen at the falling edge
      live = reset_n;
      if (live && write_req && ready)
      begin
        key = int'({addr, ~burst_begin});
        cur = mem.exists(key) ? mem[key] : '0;
        for (int i = 0; i < BYTE_LANES; i++)
          if (be[i])
            cur[i*LANE_W +: LANE_W] = wdata[i*LANE_W +: LANE_W];
        mem[key] = cur;
        wr_beats = wr_beats + 1;
        if (burst_begin)
        begin
          wr_bursts = wr_bursts + 1;
          if (hits.exists(int'(addr)))
            hits[int'(addr)] = hits[int'(addr)] + 1;
          else
            hits[int'(addr)] = 1;
        end
      end
      if (live && read_req && ready)
      begin
        rd_reqs = rd_reqs + 1;
        for (int b = 0; b < BURST_LEN; b++)
        begin
          ent.key = int'({addr, b[0]});
          ent.due = cyc + int'(latency);
          rd_q.push_back(ent);
        end
      end
      // --------------------------------------------------
      // next cycle's ready and read data
      @(posedge clk);
      #1;
      cyc         = cyc + 1;
      rdata_valid = 1'b0;
      fault_hit   = 1'b0;
      if (!live)
      begin
        ready     = 1'b0;
        wr_beats  = 0;
        wr_bursts = 0;
        rd_reqs   = 0;
        rd_beats  = 0;
        rd_q.delete();
        hits.delete();
        mem.delete();
      end
      else
      begin
        for (int i = 0; i < 3; i++)
        begin
          lfsr = lfsr_step(lfsr);
          pick = {pick[1:0], lfsr[0]};
        end
        ready = (pick >= stall);
        if (rd_q.size() > 0 && rd_q[0].due <= cyc)
        begin
          ent   = rd_q.pop_front();
          rdata = mem.exists(ent.key) ? mem[ent.key] : '0;
          if (rd_beats == int'(fault_beat))
          begin
            for (int i = 0; i < BYTE_LANES; i++)
              if (fault_lanes[i])
                rdata[i*LANE_W +: LANE_W] = rdata[i*LANE_W +: LANE_W] ^ 8'h5a;
            fault_hit = 1'b1;
          end
          rdata_valid = 1'b1;
          rd_beats    = rd_beats + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/traffic_driver_assert.sv
// Local-port protocol assertions, bound into every traffic_driver instance.
`default_nettype none

module traffic_driver_assert
  import drv_pkg::*;
(
  input wire                  clk,
  input wire                  reset_n,
  input wire                  write_req,
  input wire                  read_req,
  input wire                  burst_begin,
  input wire                  ready,
  input mem_addr_t            addr,
  input wire [DATA_W-1:0]     wdata,
  input wire [BYTE_LANES-1:0] be
);

  a_req_excl: assert property (@(posedge clk) disable iff (!reset_n)
    !(write_req && read_req))
    else $error("write_req and read_req high together");

  a_begin_req: assert property (@(posedge clk) disable iff (!reset_n)
    burst_begin |-> (write_req || read_req))
    else $error("burst_begin without a request");

  // stalled write keeps its whole beat
  a_wr_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (write_req && !ready) |=> ($stable(write_req) && $stable(burst_begin) &&
                              $stable(addr) && $stable(wdata) && $stable(be)))
    else $error("write beat changed under back-pressure");

  a_rd_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (read_req && !ready) |=> ($stable(read_req) && $stable(burst_begin) && $stable(addr)))
    else $error("read request changed under back-pressure");

endmodule

bind traffic_driver traffic_driver_assert u_assert (
  .clk        (clk),
  .reset_n    (reset_n),
  .write_req  (write_req),
  .read_req   (read_req),
  .burst_begin(burst_begin),
  .ready      (ready),
  .addr       (addr),
  .wdata      (wdata),
  .be         (be)
);

`default_nettype wire

// File: dv/tb_traffic_driver.sv
// Testbench for the DDR2 traffic driver. Runs each row of the scenario table from
// reset to the first test_complete pulse against the memory model and checks the
// status, the pass flags, the written beats and the memory traffic counts.
`default_nettype none

module tb_traffic_driver
  import drv_pkg::*;
();

  typedef struct packed {
    logic [2:0]            stall;
    logic [7:0]            latency;
    logic [BYTE_LANES-1:0] fault_lanes;
    logic [11:0]           fault_beat;
    logic                  exp_persist;
    logic [BYTE_LANES-1:0] exp_pnf;
  } row_t;

  localparam int ROWS        = 4;
  localparam int BURSTS      = ((MAX_COL / COL_STEP) + 1) * (MAX_ROW + 1) * (MAX_BANK + 1);
  localparam int CYCLE_LIMIT = ROWS * (3 * BURSTS * BURST_LEN * 8) + 5000;

  logic clk = 1'b0;
  logic reset_n;
  logic ready, rdata_valid, fault_hit;
  logic [DATA_W-1:0] rdata, wdata;
  logic write_req, read_req, burst_begin, pnf_persist, test_complete;
  mem_addr_t addr;
  logic [BYTE_LANES-1:0] be, pnf_per_byte, fault_lanes;
  logic [STATUS_W-1:0] test_status;
  logic [2:0] stall;
  logic [7:0] latency;
  logic [11:0] fault_beat;
  int wr_beats, wr_bursts, rd_reqs, rd_beats;
  int cycles = 0;
  int checks = 0;
  int errors = 0;
  row_t rows [ROWS];

  always #5 clk = ~clk;

  traffic_driver UUT (
    .clk(clk), .reset_n(reset_n), .ready(ready), .rdata_valid(rdata_valid), .rdata(rdata),
    .write_req(write_req), .read_req(read_req), .burst_begin(burst_begin), .addr(addr),
    .wdata(wdata), .be(be), .pnf_per_byte(pnf_per_byte), .pnf_persist(pnf_persist),
    .test_status(test_status), .test_complete(test_complete)
  );

  mem_model u_mem (
    .clk(clk), .reset_n(reset_n), .write_req(write_req), .read_req(read_req),
    .burst_begin(burst_begin), .addr(addr), .wdata(wdata), .be(be), .stall(stall),
    .latency(latency), .fault_lanes(fault_lanes), .fault_beat(fault_beat), .ready(ready),
    .rdata_valid(rdata_valid), .rdata(rdata), .fault_hit(fault_hit), .wr_beats(wr_beats),
    .wr_bursts(wr_bursts), .rd_reqs(rd_reqs), .rd_beats(rd_beats)
  );

  // watchdog over the whole run
  always @(negedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT)
    begin
      $display("timeout: no test_complete within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  // each byte lane advanced once, x^8+x^6+x^5+x^4+1 shifted left
  function automatic logic [DATA_W-1:0] next_pattern(input logic [DATA_W-1:0] cur);
    logic [DATA_W-1:0] nxt;
    logic [LANE_W-1:0] lane;
    nxt = '0;
    for (int i = 0; i < BYTE_LANES; i++)
    begin
      lane = cur[i*LANE_W +: LANE_W];
      nxt[i*LANE_W +: LANE_W] = {lane[6:0], lane[7] ^ lane[5] ^ lane[4] ^ lane[3]};
    end
    return nxt;
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      $display("ERROR %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic check_idle(input string when);
    check_val({"write_req ", when}, 32'(1'b0), 32'(write_req));
    check_val({"read_req ", when}, 32'(1'b0), 32'(read_req));
    check_val({"burst_begin ", when}, 32'(1'b0), 32'(burst_begin));
    check_val({"test_complete ", when}, 32'(1'b0), 32'(test_complete));
    check_val({"test_status ", when}, 32'(8'h00), 32'(test_status));
    check_val({"be ", when}, 32'(4'hf), 32'(be));
    check_val({"pnf_persist ", when}, 32'(1'b0), 32'(pnf_persist));
    check_val({"pnf_per_byte ", when}, 32'(4'h0), 32'(pnf_per_byte));
  endtask

  // every burst address of the range, written once per write pass
  task automatic check_addresses();
    mem_addr_t a;
    a = '0;
    check_val("distinct burst addresses", 32'(BURSTS), 32'(u_mem.hits.num()));
    for (int b = 0; b <= MAX_BANK; b++)
      for (int r = 0; r <= MAX_ROW; r++)
        for (int c = 0; c <= MAX_COL; c += COL_STEP)
        begin
          a.bank = BANK_W'(b);
          a.row  = ROW_W'(r);
          a.col  = COL_W'(c);
          check_true(u_mem.hits.exists(int'(a)) && u_mem.hits[int'(a)] == 3,
                     $sformatf("address bank %0d row %0d col %0d not written 3 times", b, r, c));
        end
  endtask

  task automatic run_row(input int idx);
    row_t cfg;
    logic done, seen_seq, seen_mask, fault_done;
    logic [BYTE_LANES-1:0] exp_lanes;
    logic [BYTE_LANES-1:0] exp_be;
    logic [DATA_W-1:0] exp_wdata;
    int fault_wait, start, err_start;
    int mask_beats;
    cfg = rows[idx];
    done = 1'b0;
    seen_seq = 1'b0;
    seen_mask = 1'b0;
    fault_done = 1'b0;
    exp_lanes = ~cfg.fault_lanes;
    exp_be = '1;
    // lane seeds 31, 21, 11 and 1, lane 0 in the low byte
    exp_wdata = 32'h1f150b01;
    mask_beats = 0;
    fault_wait = 0;
    err_start = errors;
    @(posedge clk);
    #1;
    reset_n = 1'b0;
    stall = cfg.stall;
    latency = cfg.latency;
    fault_lanes = cfg.fault_lanes;
    fault_beat = cfg.fault_beat;
    repeat (16) @(posedge clk);
    #1;
    check_idle("in reset");
    reset_n = 1'b1;
    #1;
    check_idle("after reset");
    start = cycles;
    while (!done)
    begin
      @(negedge clk);
      // accepted write beat against the lane pattern and the enable walk
      if (write_req && ready)
      begin
        if (test_status == 8'h04 && mask_beats < BURSTS * BURST_LEN)
        begin
          check_val("wdata", 32'h0, wdata);
          check_val("be", 32'(4'hf), 32'(be));
        end
        else
        begin
          exp_be = '1;
          if (test_status == 8'h04)
            exp_be = 4'b0001 << ((mask_beats - BURSTS * BURST_LEN) % BYTE_LANES);
          check_val("wdata", exp_wdata, wdata);
          check_val("be", 32'(exp_be), 32'(be));
          exp_wdata = next_pattern(exp_wdata);
        end
        if (test_status == 8'h04)
          mask_beats++;
      end
      if (test_status == 8'h01)
        seen_seq = 1'b1;
      if (test_status == 8'h04 && !seen_mask)
      begin
        check_true(seen_seq, "byte-mask test began before the sequential address test");
        seen_mask = 1'b1;
      end
      if (fault_done)
        check_val("pnf_persist after fault", 32'(1'b0), 32'(pnf_persist));
      if (fault_hit)
        fault_wait = 3;
      else if (fault_wait > 0)
      begin
        fault_wait--;
        if (fault_wait == 0)
        begin
          check_val("pnf_per_byte at faulted beat", 32'(exp_lanes), 32'(pnf_per_byte));
          fault_done = 1'b1;
        end
      end
      if (test_complete)
        done = 1'b1;
    end
    check_val("pnf_persist", 32'(cfg.exp_persist), 32'(pnf_persist));
    check_val("pnf_per_byte", 32'(cfg.exp_pnf), 32'(pnf_per_byte));
    check_val("test_status", 32'(8'h80), 32'(test_status));
    check_true(seen_seq && seen_mask, "test_status did not show both tests");
    if (cfg.fault_beat != 12'hfff)
      check_true(fault_done, "injected fault never reached the checker");
    check_val("write bursts", 32'(3 * BURSTS), 32'(wr_bursts));
    check_val("write beats", 32'(3 * BURSTS * BURST_LEN), 32'(wr_beats));
    check_val("read requests", 32'(2 * BURSTS), 32'(rd_reqs));
    check_val("read beats", 32'(2 * BURSTS * BURST_LEN), 32'(rd_beats));
    check_addresses();
    @(negedge clk);
    check_val("test_complete width", 32'(1'b0), 32'(test_complete));
    $display("row %0d: stall %0d latency %0d, %0d cycles, %0d errors",
             idx, cfg.stall, cfg.latency, cycles - start, errors - err_start);
  endtask

  initial
  begin
    reset_n = 1'b0;
    stall = '0;
    latency = 8'd1;
    fault_lanes = '0;
    fault_beat = 12'hfff;
    // stall, latency, fault lanes, fault beat, expected persist, expected lanes
    rows[0] = '{3'd0, 8'd1, 4'h0, 12'hfff, 1'b1, 4'hf};
    rows[1] = '{3'd3, 8'd12, 4'h0, 12'hfff, 1'b1, 4'hf};
    rows[2] = '{3'd0, 8'd3, 4'h4, 12'd37, 1'b0, 4'hf};
    rows[3] = '{3'd2, 8'd40, 4'h2, 12'd500, 1'b0, 4'hf};
    for (int r = 0; r < ROWS; r++)
      run_row(r);
    $display("rows %0d, checks %0d, errors %0d", ROWS, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
src/drv_pkg.sv
src/test_sequencer.sv
src/addr_gen.sv
src/pattern_gen.sv
src/read_checker.sv
src/traffic_driver.sv
dv/mem_model.sv
dv/traffic_driver_assert.sv
dv/tb_traffic_driver.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_traffic_driver
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Result: PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
